// ==== hdl/bus_pkg.sv ====
package bus_pkg;

	// core bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// byte address of the last instruction word
	// anything above it belongs to the data port
	localparam logic [ADDR_W-1:0] END_INST = 32'h0000_03FC;

	// legal write strobe patterns
	typedef enum logic [STRB_W-1:0] {
		BYTE0   = 4'b0001,
		BYTE1   = 4'b0010,
		BYTE2   = 4'b0100,
		BYTE3   = 4'b1000,
		HALF_LO = 4'b0011,
		HALF_HI = 4'b1100,
		WORD    = 4'b1111
	} store_size_e;

	// request as issued by the core with one-cycle rd and wr strobes
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
		logic              rd;
		logic              wr;
	} cpu_req_t;

	// request towards one cache port
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} port_req_t;

	// cache port answer where rd_ready and wr_ack pulse for one cycle
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              rd_ready;
		logic              wr_ack;
	} port_rsp_t;

endpackage

// ==== hdl/trace_pkg.sv ====
package trace_pkg;

	// uart bit time in clk cycles
	localparam int CLKS_PER_BIT = 8;

	// start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;

	// word serializer
	typedef enum logic {
		SER_IDLE,
		SER_SEND
	} ser_state_e;

	// 8N1 transmitter
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_e;

endpackage

// ==== hdl/bus_decode.sv ====
`timescale 1ns/10ps

module bus_decode (
	input  logic                            clk,
	input  logic                            rst,
	input  bus_pkg::cpu_req_t               cpu_req,
	input  logic [bus_pkg::DATA_W-1:0]      merged_wdata,
	output bus_pkg::port_req_t              inst_req,
	output bus_pkg::port_req_t              data_req,
	output logic                            sel_data,
	output logic [bus_pkg::STRB_W-1:0]      wr_strobe
);

	logic                       rd_q;
	logic                       wr_q;
	logic [bus_pkg::ADDR_W-1:0] addr_q;
	logic [bus_pkg::DATA_W-1:0] wdata_q;

	// strobe only counts while the core writes
	assign wr_strobe = cpu_req.wr ? cpu_req.wstrb : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			sel_data <= 1'b0;
		end else begin
			rd_q <= cpu_req.rd;
			wr_q <= cpu_req.wr;
			// route decided once per request and stores always hit the data port
			if (cpu_req.rd || cpu_req.wr)
				sel_data <= cpu_req.wr || (cpu_req.addr > bus_pkg::END_INST);
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_req.rd || cpu_req.wr)
			addr_q <= cpu_req.addr;
		if (cpu_req.wr)
			wdata_q <= merged_wdata;
	end

	always_comb begin
		inst_req.addr  = addr_q;
		inst_req.wdata = '0;
		inst_req.rd    = rd_q && !sel_data;
		inst_req.wr    = 1'b0;

		data_req.addr  = addr_q;
		data_req.wdata = wdata_q;
		data_req.rd    = rd_q && sel_data;
		data_req.wr    = wr_q;
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (rst)
		!(cpu_req.rd && cpu_req.wr));

	// one strobe on one port per cycle
	a_one_port: assert property (@(posedge clk) disable iff (rst)
		!(data_req.rd && data_req.wr) &&
		!((inst_req.rd || inst_req.wr) && (data_req.rd || data_req.wr)));

endmodule

// ==== hdl/store_merge.sv ====
`timescale 1ns/10ps

module store_merge (
	input  logic [bus_pkg::STRB_W-1:0] wr_strobe,
	input  logic [bus_pkg::DATA_W-1:0] wdata,
	input  logic [bus_pkg::DATA_W-1:0] held_word,
	output logic [bus_pkg::DATA_W-1:0] merged_wdata
);

	logic [bus_pkg::DATA_W-1:0] lane_mix;
	logic                       legal;

	// byte lanes from wdata where enabled, held word elsewhere
	always_comb begin
		for (int i = 0; i < bus_pkg::STRB_W; i++) begin
			lane_mix[8*i +: 8] = wr_strobe[i] ? wdata[8*i +: 8] : held_word[8*i +: 8];
		end
	end

	always_comb begin
		case (bus_pkg::store_size_e'(wr_strobe))
			bus_pkg::WORD: begin
				merged_wdata = wdata;
				legal        = 1'b1;
			end
			bus_pkg::BYTE0, bus_pkg::BYTE1, bus_pkg::BYTE2, bus_pkg::BYTE3,
			bus_pkg::HALF_LO, bus_pkg::HALF_HI: begin
				merged_wdata = lane_mix;
				legal        = 1'b1;
			end
			default: begin
				// unsupported pattern, store zero
				merged_wdata = '0;
				legal        = 1'b0;
			end
		endcase
	end

	// zero strobe means no write in this cycle
	always_comb begin
		if (wr_strobe != '0) begin
			a_legal_strobe: assert (legal)
				else $error("illegal write strobe %b", wr_strobe);
		end
	end

endmodule

// ==== hdl/response_select.sv ====
`timescale 1ns/10ps

module response_select (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       sel_data,
	input  bus_pkg::port_rsp_t         inst_rsp,
	input  bus_pkg::port_rsp_t         data_rsp,
	output logic [bus_pkg::DATA_W-1:0] read_data,
	output logic                       read_response,
	output logic                       write_response,
	output logic [bus_pkg::DATA_W-1:0] held_word
);

	bus_pkg::port_rsp_t sel_rsp;

	// port picked at decode time
	assign sel_rsp = sel_data ? data_rsp : inst_rsp;

	always_ff @(posedge clk) begin
		if (rst) begin
			read_response  <= 1'b0;
			write_response <= 1'b0;
		end else begin
			read_response  <= sel_rsp.rd_ready;
			write_response <= data_rsp.wr_ack;
		end
	end

	always_ff @(posedge clk) begin
		// read data holds until the next ready
		if (sel_rsp.rd_ready)
			read_data <= sel_rsp.rdata;
		// base word for partial stores
		if (sel_data && data_rsp.rd_ready)
			held_word <= data_rsp.rdata;
	end

	// a port answers only for the route chosen in bus_decode
	a_ready_from_selected: assert property (@(posedge clk) disable iff (rst)
		!(inst_rsp.rd_ready && sel_data) && !(data_rsp.rd_ready && !sel_data));

	// write acks only follow a store, which selects the data port
	a_write_response: assert property (@(posedge clk) disable iff (rst)
		data_rsp.wr_ack |-> sel_data);

endmodule

// ==== hdl/word_serializer.sv ====
`timescale 1ns/10ps

module word_serializer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [bus_pkg::DATA_W-1:0] word,
	input  logic                       word_valid,
	input  logic                       uart_ready,
	output logic [7:0]                 byte_out,
	output logic                       tx_start,
	output logic                       trace_overflow
);

	trace_pkg::ser_state_e      state;
	logic [bus_pkg::DATA_W-1:0] buf_word;
	logic [bus_pkg::DATA_W-1:0] shift_word;
	logic                       buf_full;
	logic [1:0]                 byte_cnt;
	logic                       load_shift;
	logic                       accept;

	// buffer moves into the shifter when idle
	assign load_shift = (state == trace_pkg::SER_IDLE) && buf_full;
	assign accept     = word_valid && (!buf_full || load_shift);
	assign byte_out   = shift_word[7:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			state          <= trace_pkg::SER_IDLE;
			buf_full       <= 1'b0;
			byte_cnt       <= 2'd0;
			tx_start       <= 1'b0;
			trace_overflow <= 1'b0;
		end else begin
			// one pulse per ready and never back to back
			tx_start <= (state == trace_pkg::SER_SEND) && uart_ready && !tx_start;

			if (word_valid && !accept)
				trace_overflow <= 1'b1;

			if (accept)
				buf_full <= 1'b1;
			else if (load_shift)
				buf_full <= 1'b0;

			case (state)
				trace_pkg::SER_IDLE: begin
					if (buf_full) begin
						state    <= trace_pkg::SER_SEND;
						byte_cnt <= 2'd0;
					end
				end
				trace_pkg::SER_SEND: begin
					if (tx_start) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (byte_cnt == 2'd3)
							state <= trace_pkg::SER_IDLE;
					end
				end
				default: state <= trace_pkg::SER_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			buf_word <= word;
		// low byte first
		if (load_shift)
			shift_word <= buf_word;
		else if (tx_start)
			shift_word <= shift_word >> 8;
	end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] byte_in,
	input  logic       tx_start,
	output logic       tx,
	output logic       ready
);

	trace_pkg::uart_state_e                      state;
	logic [$clog2(trace_pkg::CLKS_PER_BIT)-1:0] clk_cnt;
	logic [2:0]                                  bit_idx;
	logic [7:0]                                  shreg;
	logic                                        bit_done;

	assign bit_done = (clk_cnt == ($bits(clk_cnt))'(trace_pkg::CLKS_PER_BIT - 1));
	assign ready    = (state == trace_pkg::TX_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= trace_pkg::TX_IDLE;
			tx      <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= 3'd0;
		end else begin
			clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
			case (state)
				trace_pkg::TX_IDLE: begin
					clk_cnt <= '0;
					if (tx_start) begin
						tx    <= 1'b0;
						state <= trace_pkg::TX_START;
					end
				end
				trace_pkg::TX_START: begin
					if (bit_done) begin
						tx      <= shreg[0];
						bit_idx <= 3'd0;
						state   <= trace_pkg::TX_DATA;
					end
				end
				trace_pkg::TX_DATA: begin
					if (bit_done) begin
						// data bits are the frame minus start and stop
						if (bit_idx == 3'(trace_pkg::FRAME_BITS - 3)) begin
							tx    <= 1'b1;
							state <= trace_pkg::TX_STOP;
						end else begin
							tx      <= shreg[1];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				trace_pkg::TX_STOP: begin
					if (bit_done)
						state <= trace_pkg::TX_IDLE;
				end
				default: state <= trace_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready && tx_start)
			shreg <= byte_in;
		else if (state == trace_pkg::TX_DATA && bit_done)
			shreg <= shreg >> 1;
	end

	// the serializer only starts a byte while ready is high
	a_start_when_ready: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> ready);

endmodule

// ==== hdl/cpu_bridge_top.sv ====
`timescale 1ns/10ps

module cpu_bridge_top (
	input  logic                       clk,
	input  logic                       rst,
	input  bus_pkg::cpu_req_t          cpu_req,
	output logic [bus_pkg::DATA_W-1:0] read_data,
	output logic                       read_response,
	output logic                       write_response,
	output bus_pkg::port_req_t         inst_req,
	input  bus_pkg::port_rsp_t         inst_rsp,
	output bus_pkg::port_req_t         data_req,
	input  bus_pkg::port_rsp_t         data_rsp,
	output logic                       tx,
	output logic                       trace_overflow
);

	logic                       sel_data;
	logic [bus_pkg::STRB_W-1:0] wr_strobe;
	logic [bus_pkg::DATA_W-1:0] merged_wdata;
	logic [bus_pkg::DATA_W-1:0] held_word;
	logic [7:0]                 trace_byte;
	logic                       tx_start;
	logic                       uart_ready;

	bus_decode u_bus_decode (
		.clk          (clk),
		.rst          (rst),
		.cpu_req      (cpu_req),
		.merged_wdata (merged_wdata),
		.inst_req     (inst_req),
		.data_req     (data_req),
		.sel_data     (sel_data),
		.wr_strobe    (wr_strobe)
	);

	store_merge u_store_merge (
		.wr_strobe    (wr_strobe),
		.wdata        (cpu_req.wdata),
		.held_word    (held_word),
		.merged_wdata (merged_wdata)
	);

	response_select u_response_select (
		.clk            (clk),
		.rst            (rst),
		.sel_data       (sel_data),
		.inst_rsp       (inst_rsp),
		.data_rsp       (data_rsp),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.held_word      (held_word)
	);

	// trace taps every instruction fetch
	word_serializer u_word_serializer (
		.clk            (clk),
		.rst            (rst),
		.word           (inst_rsp.rdata),
		.word_valid     (inst_rsp.rd_ready),
		.uart_ready     (uart_ready),
		.byte_out       (trace_byte),
		.tx_start       (tx_start),
		.trace_overflow (trace_overflow)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst      (rst),
		.byte_in  (trace_byte),
		.tx_start (tx_start),
		.tx       (tx),
		.ready    (uart_ready)
	);

endmodule

// ==== sim/tb_cpu_bridge.sv ====
`timescale 1ns/10ps

module tb_cpu_bridge;

	typedef logic [bus_pkg::DATA_W-1:0] word_t;

	localparam int N_RAND       = 40;
	localparam int N_TRACE      = 4;
	localparam int N_BURST      = 6;
	localparam int LAT_MAX      = 16;
	localparam int FRAME_CYC    = trace_pkg::FRAME_BITS * trace_pkg::CLKS_PER_BIT;
	localparam int WORD_CYC     = 4 * (FRAME_CYC + 4);
	localparam int WATCHDOG_CYC = (2 * N_RAND + N_TRACE + N_BURST + 4) * LAT_MAX
		+ (N_TRACE + 3) * 2 * WORD_CYC;
	localparam word_t INST_SALT = 32'h1C0D_E5A7;
	localparam word_t DATA_SALT = 32'h0DA7_A5E1;

	logic               clk = 1'b0;
	logic               rst;
	bus_pkg::cpu_req_t  cpu_req;
	word_t              read_data;
	logic               read_response;
	logic               write_response;
	bus_pkg::port_req_t inst_req;
	bus_pkg::port_rsp_t inst_rsp;
	bus_pkg::port_req_t data_req;
	bus_pkg::port_rsp_t data_rsp;
	logic               tx;
	logic               trace_overflow;

	// reference state
	word_t ref_mem [word_t];
	word_t dmem [word_t];
	word_t fetched [$];
	word_t last_read;
	logic  allow_drop;
	int    reads_issued = 0;
	int    writes_issued = 0;
	int    rd_rsp_cnt = 0;
	int    wr_rsp_cnt = 0;
	int    rx_words = 0;

	cpu_bridge_top i_cpu_bridge_top (
		.clk            (clk),
		.rst            (rst),
		.cpu_req        (cpu_req),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.inst_req       (inst_req),
		.inst_rsp       (inst_rsp),
		.data_req       (data_req),
		.data_rsp       (data_rsp),
		.tx             (tx),
		.trace_overflow (trace_overflow)
	);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_req(input string what, input bus_pkg::port_req_t got,
		input bus_pkg::port_req_t exp);
		// wdata only matters on a write
		if (got.addr !== exp.addr || got.rd !== exp.rd || got.wr !== exp.wr
			|| (exp.wr && got.wdata !== exp.wdata)) begin
			$display("** Error at %0t ns: %s addr %h wdata %h rd %b wr %b, expected %h %h %b %b",
				$time, what, got.addr, got.wdata, got.rd, got.wr,
				exp.addr, exp.wdata, exp.rd, exp.wr);
			stop_run();
		end
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_counts();
		if (rd_rsp_cnt != reads_issued || wr_rsp_cnt != writes_issued) begin
			$display("response count wrong at %0t ns: %0d reads, %0d read responses,",
				$time, reads_issued, rd_rsp_cnt);
			$display("    %0d writes, %0d write responses", writes_issued, wr_rsp_cnt);
			stop_run();
		end
	endtask

	// response lands exactly one cycle after the port pulse
	task automatic wait_response(input logic is_write);
		logic pulsed;
		logic rsp;
		pulsed = 1'b0;
		rsp    = 1'b0;
		while (rsp !== 1'b1) begin
			if (pulsed) begin
				$display("no response at %0t ns one cycle after the port pulse", $time);
				stop_run();
			end
			pulsed = is_write ? (data_rsp.wr_ack === 1'b1)
				: (inst_rsp.rd_ready === 1'b1 || data_rsp.rd_ready === 1'b1);
			@(negedge clk);
			rsp = is_write ? write_response : read_response;
		end
		if (!pulsed) begin
			$display("response at %0t ns without a port pulse in the cycle before", $time);
			stop_run();
		end
	endtask

	function automatic word_t fill_word(input word_t addr, input word_t salt);
		return (addr ^ salt) * 32'h9E37_79B9;
	endfunction

	function automatic word_t ref_word(input word_t addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr, DATA_SALT);
	endfunction

	// strobed lanes from the new word, the rest from the last data read
	function automatic word_t merge_model(input word_t old_word, input word_t new_word,
		input logic [bus_pkg::STRB_W-1:0] strb);
		word_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (new_word & mask) | (old_word & ~mask);
	endfunction

	function automatic bus_pkg::port_req_t port_exp(input word_t addr, input word_t wdata,
		input logic rd, input logic wr);
		bus_pkg::port_req_t r;
		r.addr  = addr;
		r.wdata = wdata;
		r.rd    = rd;
		r.wr    = wr;
		return r;
	endfunction

	function automatic bus_pkg::store_size_e pick_size();
		case ($urandom_range(0, 6))
			0: return bus_pkg::BYTE0;
			1: return bus_pkg::BYTE1;
			2: return bus_pkg::BYTE2;
			3: return bus_pkg::BYTE3;
			4: return bus_pkg::HALF_LO;
			5: return bus_pkg::HALF_HI;
			default: return bus_pkg::WORD;
		endcase
	endfunction

	task automatic do_read(input word_t addr);
		word_t exp_data;
		logic  to_data;
		to_data = addr > bus_pkg::END_INST;
		@(posedge clk);
		check_counts();
		#1;
		cpu_req      = '0;
		cpu_req.addr = addr;
		cpu_req.rd   = 1'b1;
		@(posedge clk);
		#1;
		cpu_req.rd = 1'b0;
		@(negedge clk);
		check_req("inst_req", inst_req, port_exp(addr, '0, !to_data, 1'b0));
		check_req("data_req", data_req, port_exp(addr, '0, to_data, 1'b0));
		reads_issued++;
		wait_response(1'b0);
		exp_data = to_data ? ref_word(addr) : fill_word(addr, INST_SALT);
		check_word("read_data", read_data, exp_data);
		if (to_data)
			last_read = exp_data;
	endtask

	task automatic do_write(input word_t addr, input word_t wdata,
		input bus_pkg::store_size_e size);
		word_t merged;
		merged = merge_model(last_read, wdata, size);
		@(posedge clk);
		check_counts();
		#1;
		cpu_req       = '0;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_req.wstrb = size;
		cpu_req.wr    = 1'b1;
		@(posedge clk);
		#1;
		cpu_req.wr = 1'b0;
		@(negedge clk);
		check_req("inst_req", inst_req, port_exp(addr, '0, 1'b0, 1'b0));
		check_req("data_req", data_req, port_exp(addr, merged, 1'b0, 1'b1));
		writes_issued++;
		ref_mem[addr] = merged;
		wait_response(1'b1);
	endtask

	// dropped words leave gaps in the fetch order
	task automatic match_trace(input word_t w);
		while (allow_drop && fetched.size() > 1 && fetched[0] !== w)
			void'(fetched.pop_front());
		if (fetched.size() == 0) begin
			$display("trace word %h at %0t ns has no matching fetch", w, $time);
			stop_run();
		end
		for (int b = 0; b < 4; b++)
			check_byte("trace byte", 8'(w >> (8 * b)), 8'(fetched[0] >> (8 * b)));
		void'(fetched.pop_front());
		rx_words++;
	endtask

	always @(negedge clk) begin
		if (!rst && read_response === 1'b1)
			rd_rsp_cnt++;
		if (!rst && write_response === 1'b1)
			wr_rsp_cnt++;
	end

	// read-only instruction cache
	initial begin : inst_port
		word_t addr;
		inst_rsp = '0;
		forever begin
			@(negedge clk);
			if (!rst && inst_req.rd === 1'b1) begin
				addr = inst_req.addr;
				repeat ($urandom_range(1, 6)) @(posedge clk);
				#1;
				inst_rsp.rdata    = fill_word(addr, INST_SALT);
				inst_rsp.rd_ready = 1'b1;
				fetched.push_back(fill_word(addr, INST_SALT));
				@(posedge clk);
				#1;
				inst_rsp = '0;
			end
		end
	end

	initial begin : data_port
		word_t addr;
		logic  is_rd;
		data_rsp = '0;
		forever begin
			@(negedge clk);
			if (!rst && (data_req.rd === 1'b1 || data_req.wr === 1'b1)) begin
				addr  = data_req.addr;
				is_rd = data_req.rd;
				if (!is_rd)
					dmem[addr] = data_req.wdata;
				repeat ($urandom_range(1, 6)) @(posedge clk);
				#1;
				if (is_rd)
					data_rsp.rdata = dmem.exists(addr) ? dmem[addr]
						: fill_word(addr, DATA_SALT);
				data_rsp.rd_ready = is_rd;
				data_rsp.wr_ack   = !is_rd;
				@(posedge clk);
				#1;
				data_rsp = '0;
			end
		end
	end

	initial begin : uart_rx
		logic [7:0] rx_byte;
		word_t      rx_word;
		int         nbytes;
		nbytes  = 0;
		rx_byte = '0;
		rx_word = '0;
		forever begin
			@(negedge clk);
			if (!rst && tx === 1'b0) begin
				// middle of the start bit, then one bit time per sample
				repeat (trace_pkg::CLKS_PER_BIT / 2) @(negedge clk);
				repeat (8) begin
					repeat (trace_pkg::CLKS_PER_BIT) @(negedge clk);
					rx_byte = {tx, rx_byte[7:1]};
				end
				repeat (trace_pkg::CLKS_PER_BIT) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("uart frame at %0t ns has no stop bit", $time);
					stop_run();
				end
				rx_word = {rx_byte, rx_word[31:8]};
				nbytes++;
				if (nbytes == 4) begin
					match_trace(rx_word);
					nbytes = 0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYC * 8);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
		stop_run();
	end

	initial begin : main
		word_t addr;
		void'($urandom(73217));
		rst        = 1'b1;
		cpu_req    = '0;
		allow_drop = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		// strobes low, tx idle high
		check_word("idle outputs", {24'd0, inst_req.rd, inst_req.wr, data_req.rd, data_req.wr,
			read_response, write_response, tx, trace_overflow}, 32'h0000_0002);

		// data side with read-modify-write
		do_read(bus_pkg::END_INST + 32'd4);
		for (int i = 0; i < N_RAND; i++) begin
			addr = bus_pkg::END_INST + 32'd4 + (32'($urandom_range(0, 63)) << 2);
			do_read(addr);
			if ($urandom_range(0, 1) == 1)
				do_write(addr, $urandom(), pick_size());
		end

		// fetches slow enough for the uart
		for (int i = 0; i < N_TRACE; i++) begin
			addr = (i == 0) ? bus_pkg::END_INST : 32'($urandom_range(0, 255)) << 2;
			do_read(addr);
			repeat (4 * FRAME_CYC + 16) @(posedge clk);
		end
		wait (rx_words == N_TRACE);
		@(negedge clk);
		check_word("trace_overflow", {31'd0, trace_overflow}, 32'd0);

		// in a burst only the sending word and the buffered one survive
		allow_drop = 1'b1;
		for (int i = 0; i < N_BURST; i++)
			do_read(32'($urandom_range(0, 255)) << 2);
		wait (rx_words == N_TRACE + 2);
		@(negedge clk);
		check_counts();
		check_word("trace_overflow", {31'd0, trace_overflow}, 32'd1);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/bus_pkg.sv
hdl/trace_pkg.sv
hdl/bus_decode.sv
hdl/store_merge.sv
hdl/response_select.sv
hdl/word_serializer.sv
hdl/uart_tx.sv
hdl/cpu_bridge_top.sv
sim/tb_cpu_bridge.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module tb_cpu_bridge --Mdir $(OBJ_DIR) -o tb_cpu_bridge

run: compile
	./$(OBJ_DIR)/tb_cpu_bridge | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
